//--- soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Bus widths
`define ALEN 32
`define XLEN 64

// Region select lives in the address bits from here up to ALEN-1
`define REGION_LSB 28

// Region ids, compared against addr[ALEN-1:REGION_LSB]
`define SRAM_BASE 4'h1
`define GPIO_BASE 4'h2

// SRAM depth in XLEN words
`define SRAM_WORDS 512

// Default width of the GPIO output register
`define GPIO_OUTPUTS 8

`endif

//--- bus_pkg.sv
`include "soc_config.svh"

package bus_pkg;

    // AXI-style response encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // Request channel payload
    typedef struct packed {
        logic [`ALEN-1:0]   addr;
        logic               write;
        logic [`XLEN-1:0]   wdata;
        logic [`XLEN/8-1:0] wstrb;
    } bus_req_t;

    // Response channel payload
    typedef struct packed {
        logic [`XLEN-1:0] rdata;
        resp_e            resp;
    } bus_rsp_t;

    // Byte-wise merge of new data into an old word
    function automatic logic [`XLEN-1:0] strb_merge(
        input logic [`XLEN-1:0]   old_word,
        input logic [`XLEN-1:0]   new_word,
        input logic [`XLEN/8-1:0] strb
    );
        logic [`XLEN-1:0] merged;
        merged = old_word;
        for (int i = 0; i < `XLEN/8; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- soc_map_pkg.sv
`include "soc_config.svh"

package soc_map_pkg;

    // Target of a decoded address
    typedef enum logic [1:0] {
        DEV_SRAM = 2'd0,
        DEV_GPIO = 2'd1,
        DEV_NONE = 2'd2
    } dev_sel_e;

    // Top address nibble picks the region
    function automatic dev_sel_e decode_addr(input logic [`ALEN-1:0] addr);
        logic [`ALEN-`REGION_LSB-1:0] region;
        dev_sel_e sel;
        region = addr[`ALEN-1:`REGION_LSB];
        if (region == `SRAM_BASE) begin
            sel = DEV_SRAM;
        end else if (region == `GPIO_BASE) begin
            sel = DEV_GPIO;
        end else begin
            sel = DEV_NONE;
        end
        return sel;
    endfunction

endpackage

//--- bus_reg_slice.sv
`timescale 1ns/100ps

module bus_reg_slice #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,

    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,

    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    T     skid_data;
    logic skid_valid;
    logic in_fire;
    logic out_free;

    assign in_fire  = in_valid && in_ready;
    assign out_free = !out_valid || out_ready;

    // Ready comes straight from the skid flop with no path from out_ready
    assign in_ready = !skid_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // Skid entry drains first
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_fire;
            end
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (in_fire && !out_free) begin
            skid_data <= in_data;
        end
    end

    // Held output stays put until it is taken
    a_out_hold: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

endmodule

//--- bus_xbar_ctrl.sv
`timescale 1ns/100ps

module bus_xbar_ctrl (
    input  logic               clk,
    input  logic               rst,

    // Instruction-fetch master
    input  bus_pkg::bus_req_t  ifetch_req,
    input  logic               ifetch_req_valid,
    output logic               ifetch_req_ready,
    output bus_pkg::bus_rsp_t  ifetch_rsp,
    output logic               ifetch_rsp_valid,
    input  logic               ifetch_rsp_ready,

    // Data master
    input  bus_pkg::bus_req_t  data_req,
    input  logic               data_req_valid,
    output logic               data_req_ready,
    output bus_pkg::bus_rsp_t  data_rsp,
    output logic               data_rsp_valid,
    input  logic               data_rsp_ready,

    // Shared device request
    output bus_pkg::bus_req_t  dev_req,
    output logic               sram_valid,
    output logic               gpio_valid,

    input  logic               sram_ready,
    input  bus_pkg::bus_rsp_t  sram_rsp,
    input  logic               sram_rsp_valid,
    input  logic               gpio_ready,
    input  bus_pkg::bus_rsp_t  gpio_rsp,
    input  logic               gpio_rsp_valid
);

    import bus_pkg::*;
    import soc_map_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT,
        S_RESP
    } state_e;

    state_e   state;
    dev_sel_e sel_q;
    bus_req_t req_q;
    bus_rsp_t rsp_q;

    // High when the data port holds the grant and serves as the round-robin pointer
    logic     grant_data;

    logic     any_req;
    logic     pick_data;
    bus_req_t win_req;
    dev_sel_e win_sel;
    logic     dev_fire;
    logic     dev_rsp_valid;
    bus_rsp_t dev_rsp;
    logic     rsp_fire;

    // Port whose request handshake completed last
    logic     owner_data;

    assign any_req = ifetch_req_valid || data_req_valid;

    // On a tie the port not served last wins
    always_comb begin
        if (ifetch_req_valid && data_req_valid) begin
            pick_data = !grant_data;
        end else begin
            pick_data = data_req_valid;
        end
    end

    assign win_req = pick_data ? data_req : ifetch_req;
    assign win_sel = decode_addr(win_req.addr);

    assign ifetch_req_ready = (state == S_IDLE) && !pick_data;
    assign data_req_ready   = (state == S_IDLE) && pick_data;

    assign dev_req    = req_q;
    assign sram_valid = (state == S_ISSUE) && (sel_q == DEV_SRAM);
    assign gpio_valid = (state == S_ISSUE) && (sel_q == DEV_GPIO);
    assign dev_fire   = (sram_valid && sram_ready) || (gpio_valid && gpio_ready);

    assign dev_rsp_valid = (sel_q == DEV_SRAM) ? sram_rsp_valid : gpio_rsp_valid;
    assign dev_rsp       = (sel_q == DEV_SRAM) ? sram_rsp : gpio_rsp;

    assign ifetch_rsp       = rsp_q;
    assign data_rsp         = rsp_q;
    assign ifetch_rsp_valid = (state == S_RESP) && !grant_data;
    assign data_rsp_valid   = (state == S_RESP) && grant_data;
    assign rsp_fire = (ifetch_rsp_valid && ifetch_rsp_ready) ||
                      (data_rsp_valid && data_rsp_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            sel_q      <= DEV_NONE;
            grant_data <= 1'b1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (any_req) begin
                        grant_data <= pick_data;
                        sel_q      <= win_sel;
                        // Unmapped address answers without a device
                        state      <= (win_sel == DEV_NONE) ? S_RESP : S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (dev_fire) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (dev_rsp_valid) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (rsp_fire) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && any_req) begin
            req_q <= win_req;
            rsp_q <= '{rdata: '0, resp: DECERR};
        end else if (state == S_WAIT && dev_rsp_valid) begin
            rsp_q <= dev_rsp;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_data <= 1'b0;
        end else if (ifetch_req_valid && ifetch_req_ready) begin
            owner_data <= 1'b0;
        end else if (data_req_valid && data_req_ready) begin
            owner_data <= 1'b1;
        end
    end

    // One device at a time, and only the one the address maps to
    a_one_dev: assert property (
        @(posedge clk) disable iff (rst)
        !(sram_valid && gpio_valid) &&
        (!sram_valid || decode_addr(dev_req.addr) == DEV_SRAM) &&
        (!gpio_valid || decode_addr(dev_req.addr) == DEV_GPIO)
    );

    // Response returns on the port whose request was taken
    a_rsp_to_owner: assert property (
        @(posedge clk) disable iff (rst)
        !(ifetch_rsp_valid && owner_data) && !(data_rsp_valid && !owner_data)
    );

    // A device only answers a request this controller issued
    a_dev_rsp_expected: assert property (
        @(posedge clk) disable iff (rst)
        (!sram_rsp_valid || (state == S_WAIT && sel_q == DEV_SRAM)) &&
        (!gpio_rsp_valid || (state == S_WAIT && sel_q == DEV_GPIO))
    );

endmodule

//--- bus_sram.sv
`timescale 1ns/100ps
`include "soc_config.svh"

module bus_sram #(
    parameter int WORDS = `SRAM_WORDS
) (
    input  logic              clk,
    input  logic              rst,

    input  bus_pkg::bus_req_t req,
    input  logic              req_valid,
    output logic              req_ready,

    output bus_pkg::bus_rsp_t rsp,
    output logic              rsp_valid,
    input  logic              rsp_ready
);

    import bus_pkg::*;

    localparam int IDX_W    = $clog2(WORDS);
    localparam int BYTE_OFS = $clog2(`XLEN/8);

    logic [`XLEN-1:0] mem [WORDS];
    logic [IDX_W-1:0] idx;
    logic             req_fire;

    // Low address bits select a byte within the word and are dropped
    assign idx       = req.addr[BYTE_OFS +: IDX_W];
    assign req_ready = !rsp_valid;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (req_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            if (req.write) begin
                mem[idx] <= strb_merge(mem[idx], req.wdata, req.wstrb);
            end
            rsp <= '{rdata: req.write ? '0 : mem[idx], resp: OKAY};
        end
    end

    a_idx_range: assert property (
        @(posedge clk) disable iff (rst)
        req_valid |-> (req.addr[`REGION_LSB-1:0] >> BYTE_OFS) < WORDS
    );

endmodule

//--- bus_gpio.sv
`timescale 1ns/100ps
`include "soc_config.svh"

module bus_gpio #(
    parameter int NUM_OUTPUTS = `GPIO_OUTPUTS
) (
    input  logic                   clk,
    input  logic                   rst,

    input  bus_pkg::bus_req_t      req,
    input  logic                   req_valid,
    output logic                   req_ready,

    output bus_pkg::bus_rsp_t      rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,

    output logic [NUM_OUTPUTS-1:0] outputs
);

    import bus_pkg::*;

    logic [`XLEN-1:0] cur_word;
    logic [`XLEN-1:0] new_word;
    logic             req_fire;

    // Register seen as a zero-extended bus word
    assign cur_word  = `XLEN'(outputs);
    assign new_word  = strb_merge(cur_word, req.wdata, req.wstrb);
    assign req_ready = !rsp_valid;
    assign req_fire  = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            outputs   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            if (req_fire && req.write) begin
                outputs <= new_word[NUM_OUTPUTS-1:0];
            end
            if (req_fire) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    // Whole region aliases the one register
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp <= '{rdata: req.write ? '0 : cur_word, resp: OKAY};
        end
    end

endmodule

//--- mini_soc.sv
`timescale 1ns/100ps
`include "soc_config.svh"

module mini_soc (
    input  logic                     clk,
    input  logic                     rst,

    input  bus_pkg::bus_req_t        ifetch_req,
    input  logic                     ifetch_req_valid,
    output logic                     ifetch_req_ready,
    output bus_pkg::bus_rsp_t        ifetch_rsp,
    output logic                     ifetch_rsp_valid,
    input  logic                     ifetch_rsp_ready,

    input  bus_pkg::bus_req_t        data_req,
    input  logic                     data_req_valid,
    output logic                     data_req_ready,
    output bus_pkg::bus_rsp_t        data_rsp,
    output logic                     data_rsp_valid,
    input  logic                     data_rsp_ready,

    output logic [`GPIO_OUTPUTS-1:0] gpio_outputs
);

    import bus_pkg::*;

    // Slice to crossbar
    bus_req_t ifetch_xreq;
    logic     ifetch_xreq_valid;
    logic     ifetch_xreq_ready;
    bus_req_t data_xreq;
    logic     data_xreq_valid;
    logic     data_xreq_ready;

    // Crossbar to slice
    bus_rsp_t ifetch_xrsp;
    logic     ifetch_xrsp_valid;
    logic     ifetch_xrsp_ready;
    bus_rsp_t data_xrsp;
    logic     data_xrsp_valid;
    logic     data_xrsp_ready;

    // Device side
    bus_req_t dev_req;
    logic     sram_valid;
    logic     sram_ready;
    bus_rsp_t sram_rsp;
    logic     sram_rsp_valid;
    logic     gpio_valid;
    logic     gpio_ready;
    bus_rsp_t gpio_rsp;
    logic     gpio_rsp_valid;

    bus_reg_slice #(.T(bus_req_t)) u_ifetch_req_slice (
        .clk, .rst,
        .in_data(ifetch_req), .in_valid(ifetch_req_valid), .in_ready(ifetch_req_ready),
        .out_data(ifetch_xreq), .out_valid(ifetch_xreq_valid), .out_ready(ifetch_xreq_ready)
    );

    bus_reg_slice #(.T(bus_req_t)) u_data_req_slice (
        .clk, .rst,
        .in_data(data_req), .in_valid(data_req_valid), .in_ready(data_req_ready),
        .out_data(data_xreq), .out_valid(data_xreq_valid), .out_ready(data_xreq_ready)
    );

    bus_reg_slice #(.T(bus_rsp_t)) u_ifetch_rsp_slice (
        .clk, .rst,
        .in_data(ifetch_xrsp), .in_valid(ifetch_xrsp_valid), .in_ready(ifetch_xrsp_ready),
        .out_data(ifetch_rsp), .out_valid(ifetch_rsp_valid), .out_ready(ifetch_rsp_ready)
    );

    bus_reg_slice #(.T(bus_rsp_t)) u_data_rsp_slice (
        .clk, .rst,
        .in_data(data_xrsp), .in_valid(data_xrsp_valid), .in_ready(data_xrsp_ready),
        .out_data(data_rsp), .out_valid(data_rsp_valid), .out_ready(data_rsp_ready)
    );

    bus_xbar_ctrl u_xbar (
        .clk, .rst,
        .ifetch_req(ifetch_xreq), .ifetch_req_valid(ifetch_xreq_valid),
        .ifetch_req_ready(ifetch_xreq_ready),
        .ifetch_rsp(ifetch_xrsp), .ifetch_rsp_valid(ifetch_xrsp_valid),
        .ifetch_rsp_ready(ifetch_xrsp_ready),
        .data_req(data_xreq), .data_req_valid(data_xreq_valid),
        .data_req_ready(data_xreq_ready),
        .data_rsp(data_xrsp), .data_rsp_valid(data_xrsp_valid),
        .data_rsp_ready(data_xrsp_ready),
        .dev_req, .sram_valid, .gpio_valid,
        .sram_ready, .sram_rsp, .sram_rsp_valid,
        .gpio_ready, .gpio_rsp, .gpio_rsp_valid
    );

    // Controller always takes the single response it waits for
    bus_sram #(.WORDS(`SRAM_WORDS)) u_sram (
        .clk, .rst,
        .req(dev_req), .req_valid(sram_valid), .req_ready(sram_ready),
        .rsp(sram_rsp), .rsp_valid(sram_rsp_valid), .rsp_ready(1'b1)
    );

    bus_gpio #(.NUM_OUTPUTS(`GPIO_OUTPUTS)) u_gpio (
        .clk, .rst,
        .req(dev_req), .req_valid(gpio_valid), .req_ready(gpio_ready),
        .rsp(gpio_rsp), .rsp_valid(gpio_rsp_valid), .rsp_ready(1'b1),
        .outputs(gpio_outputs)
    );

endmodule

//--- tb_mini_soc.sv
`timescale 1ns/100ps
`include "soc_config.svh"

module tb_mini_soc;

    import bus_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 16;
    localparam int N_TESTS     = 6;
    localparam int MAX_TX_TEST = 32;
    // Worst case per transaction under contention and long stalls
    localparam int TX_CYCLES   = 40;
    localparam int LIMIT_NS    = (RST_CYCLES + N_TESTS * MAX_TX_TEST * TX_CYCLES) * CLK_PERIOD;

    localparam logic [`ALEN-1:0] SRAM_ADDR = {`SRAM_BASE, {`REGION_LSB{1'b0}}};
    localparam logic [`ALEN-1:0] GPIO_ADDR = {`GPIO_BASE, {`REGION_LSB{1'b0}}};

    logic                     clk;
    logic                     rst;
    bus_req_t                 ifetch_req;
    logic                     ifetch_req_valid;
    logic                     ifetch_req_ready;
    bus_rsp_t                 ifetch_rsp;
    logic                     ifetch_rsp_valid;
    logic                     ifetch_rsp_ready;
    bus_req_t                 data_req;
    logic                     data_req_valid;
    logic                     data_req_ready;
    bus_rsp_t                 data_rsp;
    logic                     data_rsp_valid;
    logic                     data_rsp_ready;
    logic [`GPIO_OUTPUTS-1:0] gpio_outputs;

    logic [`XLEN-1:0]         sram_model [`SRAM_WORDS];
    logic [`GPIO_OUTPUTS-1:0] gpio_model;
    logic [31:0]              lcg_state;
    int                       errors;
    int                       checks;
    int                       tests_run;

    mini_soc u_mini_soc (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic string port_name(input int port);
        return (port == 0) ? "ifetch" : "data";
    endfunction

    // Byte lanes enabled by strb take the new data
    function automatic logic [`XLEN-1:0] merge_bytes(input logic [`XLEN-1:0] old_word,
                                                     input logic [`XLEN-1:0] new_word,
                                                     input logic [`XLEN/8-1:0] strb);
        logic [`XLEN-1:0] mask;
        for (int b = 0; b < `XLEN / 8; b++) begin
            mask[8*b +: 8] = {8{strb[b]}};
        end
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check_rsp(input string sig, input bus_rsp_t got, input bus_rsp_t exp,
                             input bit with_data);
        checks++;
        if (got.resp !== exp.resp) begin
            errors++;
            $display("error: %s.resp got %h expected %h", sig, got.resp, exp.resp);
        end
        if (with_data && got.rdata !== exp.rdata) begin
            errors++;
            $display("error: %s.rdata got %h expected %h", sig, got.rdata, exp.rdata);
        end
    endtask

    task automatic check_gpio(input logic [`GPIO_OUTPUTS-1:0] got,
                              input logic [`GPIO_OUTPUTS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: gpio_outputs got %h expected %h", got, exp);
        end
    endtask

    task automatic check_bit(input string sig, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", sig, got, exp);
        end
    endtask

    task automatic send_req(input int port, input bus_req_t req);
        logic rdy;
        @(negedge clk);
        if (port == 0) begin
            ifetch_req       = req;
            ifetch_req_valid = 1'b1;
        end else begin
            data_req       = req;
            data_req_valid = 1'b1;
        end
        rdy = (port == 0) ? ifetch_req_ready : data_req_ready;
        while (!rdy) begin
            @(negedge clk);
            rdy = (port == 0) ? ifetch_req_ready : data_req_ready;
        end
        // Transfer happened on the rising edge just passed
        @(negedge clk);
        if (port == 0) begin
            ifetch_req_valid = 1'b0;
        end else begin
            data_req_valid = 1'b0;
        end
    endtask

    task automatic recv_rsp(input int port, input bit stall, output bus_rsp_t rsp);
        bus_rsp_t    cur;
        bus_rsp_t    held;
        logic        vld;
        logic        rdy;
        logic        holding;
        logic        done;
        logic [31:0] r;
        holding = 1'b0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            r   = lcg_next();
            rdy = !stall || (r[17:16] == 2'b00);
            if (port == 0) begin
                ifetch_rsp_ready = rdy;
                vld = ifetch_rsp_valid;
                cur = ifetch_rsp;
            end else begin
                data_rsp_ready = rdy;
                vld = data_rsp_valid;
                cur = data_rsp;
            end
            if (holding && !vld) begin
                errors++;
                $display("%s response valid dropped before it was accepted", port_name(port));
            end else if (holding && cur !== held) begin
                errors++;
                $display("error: %s_rsp got %h expected %h", port_name(port), cur, held);
            end
            holding = vld && !rdy;
            held    = cur;
            if (vld && rdy) begin
                rsp  = cur;
                done = 1'b1;
            end
        end
        @(negedge clk);
        if (port == 0) begin
            ifetch_rsp_ready = 1'b0;
        end else begin
            data_rsp_ready = 1'b0;
        end
    endtask

    task automatic do_tx(input int port, input logic [`ALEN-1:0] addr, input logic write,
                         input logic [`XLEN-1:0] wdata, input logic [`XLEN/8-1:0] wstrb,
                         input bit stall, output bus_rsp_t rsp);
        bus_req_t req;
        req = '{addr: addr, write: write, wdata: wdata, wstrb: wstrb};
        send_req(port, req);
        recv_rsp(port, stall, rsp);
    endtask

    task automatic sram_write(input int port, input int idx, input logic [`XLEN-1:0] wdata,
                              input logic [`XLEN/8-1:0] wstrb, input bit stall);
        bus_rsp_t rsp;
        bus_rsp_t exp;
        do_tx(port, SRAM_ADDR + 32'(idx) * 8, 1'b1, wdata, wstrb, stall, rsp);
        exp = '{rdata: '0, resp: OKAY};
        check_rsp({port_name(port), "_rsp"}, rsp, exp, 1'b0);
        sram_model[idx] = merge_bytes(sram_model[idx], wdata, wstrb);
    endtask

    // Low address bits are varied since the word index ignores them
    task automatic sram_read(input int port, input int idx, input bit stall);
        bus_rsp_t rsp;
        bus_rsp_t exp;
        do_tx(port, SRAM_ADDR + 32'(idx) * 8 + 32'(idx % 8), 1'b0, '0, '0, stall, rsp);
        exp = '{rdata: sram_model[idx], resp: OKAY};
        check_rsp({port_name(port), "_rsp"}, rsp, exp, 1'b1);
    endtask

    task automatic gpio_write(input logic [`XLEN-1:0] wdata, input logic [`XLEN/8-1:0] wstrb);
        bus_rsp_t         rsp;
        bus_rsp_t         exp;
        logic [`XLEN-1:0] merged;
        do_tx(1, GPIO_ADDR, 1'b1, wdata, wstrb, 1'b0, rsp);
        exp = '{rdata: '0, resp: OKAY};
        check_rsp("data_rsp", rsp, exp, 1'b0);
        merged     = merge_bytes(`XLEN'(gpio_model), wdata, wstrb);
        gpio_model = merged[`GPIO_OUTPUTS-1:0];
        check_gpio(gpio_outputs, gpio_model);
    endtask

    task automatic gpio_read(input logic [`ALEN-1:0] offset);
        bus_rsp_t rsp;
        bus_rsp_t exp;
        do_tx(1, GPIO_ADDR + offset, 1'b0, '0, '0, 1'b0, rsp);
        exp = '{rdata: `XLEN'(gpio_model), resp: OKAY};
        check_rsp("data_rsp", rsp, exp, 1'b1);
    endtask

    task automatic test_reset();
        check_bit("ifetch_rsp_valid", ifetch_rsp_valid, 1'b0);
        check_bit("data_rsp_valid", data_rsp_valid, 1'b0);
        check_bit("ifetch_req_ready", ifetch_req_ready, 1'b1);
        check_bit("data_req_ready", data_req_ready, 1'b1);
        check_gpio(gpio_outputs, '0);
    endtask

    task automatic test_sram_strobes();
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            sram_write(1, i * 73, {lcg_next(), lcg_next()}, '1, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            r = lcg_next();
            sram_write(1, i * 73, {lcg_next(), lcg_next()}, r[15:8], 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            sram_read(1, i * 73, 1'b0);
        end
    endtask

    task automatic test_dual_read();
        fork
            for (int i = 0; i < 8; i++) begin
                sram_read(0, i * 73, 1'b0);
            end
            for (int j = 0; j < 8; j++) begin
                sram_read(1, (7 - j) * 73, 1'b0);
            end
        join
    endtask

    task automatic test_gpio();
        gpio_write({lcg_next(), lcg_next()}, '1);
        gpio_read(32'h0);
        // Byte 0 not strobed so the register keeps it
        gpio_write({lcg_next(), lcg_next()}, 8'hfe);
        gpio_read(32'h100);
        gpio_write(64'hffff_ffff_ffff_ff5a, 8'h01);
        gpio_read(32'h0ff_fff8);
    endtask

    task automatic test_decode_error();
        logic [`ALEN-1:0] holes [3];
        bus_rsp_t         rsp;
        bus_rsp_t         exp;
        holes[0] = 32'h3000_0000 + 73 * 8;
        holes[1] = 32'h0000_0000;
        holes[2] = 32'hf000_0008;
        exp = '{rdata: '0, resp: DECERR};
        for (int i = 0; i < 3; i++) begin
            do_tx(1, holes[i], 1'b1, {lcg_next(), lcg_next()}, '1, 1'b0, rsp);
            check_rsp("data_rsp", rsp, exp, 1'b1);
            do_tx(0, holes[i], 1'b0, '0, '0, 1'b0, rsp);
            check_rsp("ifetch_rsp", rsp, exp, 1'b1);
        end
        sram_read(1, 0, 1'b0);
        sram_read(1, 73, 1'b0);
        gpio_read(32'h0);
        check_gpio(gpio_outputs, gpio_model);
    endtask

    task automatic test_backpressure();
        fork
            for (int i = 0; i < 8; i++) begin
                sram_read(0, i * 73, 1'b1);
            end
            for (int j = 0; j < 8; j++) begin
                sram_write(1, 300 + j, {lcg_next(), lcg_next()}, '1, 1'b1);
                sram_read(1, 300 + j, 1'b1);
            end
        join
    endtask

    // Nothing may be left over once a test's responses are all taken
    task automatic finish_test(input string name, input int start_errors);
        repeat (4) @(negedge clk);
        check_bit("ifetch_rsp_valid", ifetch_rsp_valid, 1'b0);
        check_bit("data_rsp_valid", data_rsp_valid, 1'b0);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - start_errors);
        end
    endtask

    initial begin
        int start;
        rst              = 1'b1;
        ifetch_req       = '0;
        ifetch_req_valid = 1'b0;
        ifetch_rsp_ready = 1'b0;
        data_req         = '0;
        data_req_valid   = 1'b0;
        data_rsp_ready   = 1'b0;
        gpio_model       = '0;
        lcg_state        = 32'h251f0df7;
        errors           = 0;
        checks           = 0;
        tests_run        = 0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        start = errors;
        test_reset();
        finish_test("reset state", start);
        start = errors;
        test_sram_strobes();
        finish_test("sram strobes", start);
        start = errors;
        test_dual_read();
        finish_test("two masters", start);
        start = errors;
        test_gpio();
        finish_test("gpio register", start);
        start = errors;
        test_decode_error();
        finish_test("decode error", start);
        start = errors;
        test_backpressure();
        finish_test("back-pressure", start);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("watchdog expired, a handshake never completed");
        $display("Test failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
bus_pkg.sv
soc_map_pkg.sv
bus_reg_slice.sv
bus_xbar_ctrl.sv
bus_sram.sv
bus_gpio.sv
mini_soc.sv
tb_mini_soc.sv

//--- run.sh
#!/bin/sh
# Build and run the mini_soc testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mini_soc \
    -f verilog.f -o sim_mini_soc || { echo "verilator build failed"; exit 1; }

./obj_dir/sim_mini_soc > sim.log 2>&1
cat sim.log

grep -qx "Test passed" sim.log && exit 0 || exit 1
